// File: Makefile
VERILATOR  ?= verilator
TOP        := raster_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# the binary exits non-zero when the testbench stops with $$fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/fb_write_master.sv
// ********************
// Wishbone classic master for the framebuffer, takes one pixel request
// and holds a single write cycle for it until the slave acks
// ********************
`timescale 1ns/1ps

module fb_write_master (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   pix_valid,
	input  raster_pkg::pixel_req_t pix,
	output logic                   pix_ready,
	output raster_pkg::wb_m2s_t    fb_m2s,
	input  raster_pkg::wb_s2m_t    fb_s2m
);

	typedef enum logic {
		IDLE,
		WRITE
	} state_t;

	state_t                 state;
	raster_pkg::pixel_req_t req_q;
	logic                   accept;
	logic                   in_cycle;

	assign pix_ready = (state == IDLE);           // one write in flight at most
	assign accept    = pix_valid && pix_ready;
	assign in_cycle  = (state == WRITE);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (accept)
						state <= WRITE;
				end
				WRITE:
				begin
					if (fb_s2m.ack)
						state <= IDLE;               // next pixel can be taken next cycle
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			req_q <= pix;
	end

	// ********************
	// bus drive
	// ********************
	assign fb_m2s.cyc = in_cycle;
	assign fb_m2s.stb = in_cycle;
	assign fb_m2s.we  = in_cycle;                  // this master only ever writes
	assign fb_m2s.sel = 4'hf;
	assign fb_m2s.adr = 32'(req_q.adr);
	assign fb_m2s.dat = 32'(req_q.rgb);

endmodule

// File: design/line_stepper.sv
// ********************
// integer Bresenham stepper for any octant, pulse start to load a line
// and advance to move one point toward the far endpoint
// ********************
`timescale 1ns/1ps
`include "raster_settings.svh"

module line_stepper (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  raster_pkg::vertex_t p0,
	input  raster_pkg::vertex_t p1,
	input  logic                advance,
	output raster_pkg::vertex_t point,
	output logic                last
);

	localparam int CW = `RASTER_COORD_W;
	localparam int EW = `RASTER_COORD_W + 3;    // room for the sign and for 2 * err

	raster_pkg::vertex_t  end_pt;
	logic signed [EW-1:0] dx;                     // |x1 - x0|, zero or positive
	logic signed [EW-1:0] dy;                     // -|y1 - y0|, zero or negative
	logic signed [EW-1:0] err;
	logic                 sx;                     // x walks up when set
	logic                 sy;                     // y walks up when set

	logic [CW-1:0]        abs_dx;
	logic [CW-1:0]        abs_dy;
	logic signed [EW-1:0] dx_init;
	logic signed [EW-1:0] dy_init;
	logic signed [EW:0]   e2;
	logic                 step_x;
	logic                 step_y;

	// ********************
	// line setup
	// ********************
	assign abs_dx  = (p1.x >= p0.x) ? p1.x - p0.x : p0.x - p1.x;
	assign abs_dy  = (p1.y >= p0.y) ? p1.y - p0.y : p0.y - p1.y;
	assign dx_init = $signed({{(EW-CW){1'b0}}, abs_dx});
	assign dy_init = -$signed({{(EW-CW){1'b0}}, abs_dy});

	// ********************
	// step decision
	// ********************
	assign e2     = {err, 1'b0};
	assign step_x = (e2 >= dy);                   // signed compare, dy sign extends
	assign step_y = (e2 <= dx);
	assign last   = (point == end_pt);

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			point  <= '0;
			end_pt <= '0;
			dx     <= '0;
			dy     <= '0;
			err    <= '0;
			sx     <= 1'b0;
			sy     <= 1'b0;
		end
		else if (start)
		begin
			point  <= p0;                         // first endpoint shows up next cycle
			end_pt <= p1;
			dx     <= dx_init;
			dy     <= dy_init;
			err    <= dx_init + dy_init;
			sx     <= (p1.x >= p0.x);
			sy     <= (p1.y >= p0.y);
		end
		else if (advance && !last)
		begin
			err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
			if (step_x)
			begin
				point.x <= sx ? point.x + 1'b1 : point.x - 1'b1;
			end
			if (step_y)
			begin
				point.y <= sy ? point.y + 1'b1 : point.y - 1'b1;
			end
		end
	end

endmodule

// File: design/raster_pkg.sv
// ********************
// shared types of the rasteriser: vertices, triangles, pixel requests
// and both directions of a Wishbone classic bus
// ********************
`include "raster_settings.svh"

package raster_pkg;

	typedef struct packed {
		logic [`RASTER_COORD_W-1:0] x;
		logic [`RASTER_COORD_W-1:0] y;
	} vertex_t;

	typedef struct packed {
		vertex_t v1;
		vertex_t v2;
		vertex_t v3;                        // common endpoint of both edges
	} triangle_t;

	typedef struct packed {
		logic [`RASTER_ADDR_W-1:0] adr;     // y * width + x
		logic [23:0]               rgb;
	} pixel_req_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_m2s_t;

	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_s2m_t;

endpackage

// File: design/raster_regs.sv
// ********************
// host register block on a Wishbone classic slave, words 0-5 hold the
// vertices, word 6 the colour and word 7 start and status
// ********************
`timescale 1ns/1ps
`include "raster_settings.svh"

module raster_regs (
	input  logic                  clk,
	input  logic                  reset,
	input  raster_pkg::wb_m2s_t   host_m2s,
	output raster_pkg::wb_s2m_t   host_s2m,
	output raster_pkg::triangle_t triangle,
	output logic [23:0]           colour,
	output logic                  start,
	input  logic                  busy,
	input  logic                  pixel_done,
	input  logic                  tri_done
);

	raster_pkg::triangle_t tri_q;
	logic [23:0]           colour_q;
	logic [31:0]           rd_mux;
	logic [31:0]           rd_data;
	logic                  ack_q;
	logic                  start_q;
	logic [15:0]           run_count;           // pixels of the triangle in progress
	logic [15:0]           done_count;          // pixels of the last finished triangle
	logic                  access;
	logic                  wr_en;
	logic                  start_req;

	assign access    = host_m2s.cyc && host_m2s.stb && !ack_q;
	assign wr_en     = access && host_m2s.we;
	assign start_req = wr_en && (host_m2s.adr[2:0] == 3'd7) && host_m2s.dat[0] && !busy;

	always_comb
	begin
		case (host_m2s.adr[2:0])                   // upper address bits alias
			3'd0:    rd_mux = 32'(tri_q.v1.x);
			3'd1:    rd_mux = 32'(tri_q.v1.y);
			3'd2:    rd_mux = 32'(tri_q.v2.x);
			3'd3:    rd_mux = 32'(tri_q.v2.y);
			3'd4:    rd_mux = 32'(tri_q.v3.x);
			3'd5:    rd_mux = 32'(tri_q.v3.y);
			3'd6:    rd_mux = 32'(colour_q);
			default: rd_mux = {done_count, 15'd0, busy};
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			ack_q      <= 1'b0;
			start_q    <= 1'b0;
			run_count  <= '0;
			done_count <= '0;
		end
		else
		begin
			ack_q   <= access;                      // one cycle, then drops
			start_q <= start_req;
			if (start_req)
				run_count <= '0;
			else if (pixel_done)
				run_count <= run_count + 1'b1;
			if (tri_done)
				done_count <= run_count;
		end
	end

	always_ff @(posedge clk)
	begin
		if (access)
			rd_data <= rd_mux;
		if (wr_en)
		begin
			case (host_m2s.adr[2:0])
				3'd0: tri_q.v1.x <= host_m2s.dat[`RASTER_COORD_W-1:0];
				3'd1: tri_q.v1.y <= host_m2s.dat[`RASTER_COORD_W-1:0];
				3'd2: tri_q.v2.x <= host_m2s.dat[`RASTER_COORD_W-1:0];
				3'd3: tri_q.v2.y <= host_m2s.dat[`RASTER_COORD_W-1:0];
				3'd4: tri_q.v3.x <= host_m2s.dat[`RASTER_COORD_W-1:0];
				3'd5: tri_q.v3.y <= host_m2s.dat[`RASTER_COORD_W-1:0];
				3'd6: colour_q   <= host_m2s.dat[23:0];
				default: ;                           // control is handled by start_req
			endcase
		end
	end

	assign host_s2m.ack = ack_q;
	assign host_s2m.dat = rd_data;
	assign triangle     = tri_q;
	assign colour       = colour_q;
	assign start        = start_q;

endmodule

// File: design/raster_top.sv
// ********************
// rasteriser top level, host registers on one Wishbone port and
// framebuffer writes on the other
// ********************
`timescale 1ns/1ps

module raster_top (
	input  logic                clk,
	input  logic                reset,
	input  raster_pkg::wb_m2s_t host_m2s,
	output raster_pkg::wb_s2m_t host_s2m,
	output raster_pkg::wb_m2s_t fb_m2s,
	input  raster_pkg::wb_s2m_t fb_s2m,
	output logic                tri_done
);

	raster_pkg::triangle_t  triangle;
	logic [23:0]            colour;
	logic                   start;
	logic                   busy;
	logic                   pixel_done;
	logic                   pix_valid;
	logic                   pix_ready;
	raster_pkg::pixel_req_t pix;

	raster_regs u_regs (.clk(clk), .reset(reset), .host_m2s(host_m2s),
		.host_s2m(host_s2m), .triangle(triangle), .colour(colour), .start(start),
		.busy(busy), .pixel_done(pixel_done), .tri_done(tri_done));

	triangle_rasteriser u_rasteriser (.clk(clk), .reset(reset), .start(start),
		.triangle(triangle), .colour(colour), .pix_valid(pix_valid), .pix(pix),
		.pix_ready(pix_ready), .pixel_done(pixel_done), .tri_done(tri_done),
		.busy(busy));

	fb_write_master u_fb_master (.clk(clk), .reset(reset), .pix_valid(pix_valid),
		.pix(pix), .pix_ready(pix_ready), .fb_m2s(fb_m2s), .fb_s2m(fb_s2m));

endmodule

// File: design/triangle_rasteriser.sv
// ********************
// walks edge v1-v3 and edge v2-v3 together and fills the span between
// them, each on-screen span point leaves as one pixel request
// ********************
`timescale 1ns/1ps
`include "raster_settings.svh"

module triangle_rasteriser (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  raster_pkg::triangle_t  triangle,
	input  logic [23:0]            colour,
	output logic                   pix_valid,
	output raster_pkg::pixel_req_t pix,
	input  logic                   pix_ready,
	output logic                   pixel_done,
	output logic                   tri_done,
	output logic                   busy
);

	typedef enum logic [2:0] {
		IDLE,
		LOAD_EDGES,
		LOAD_SPAN,
		EMIT,
		STEP_SPAN,
		STEP_EDGES,
		DONE
	} state_t;

	state_t              state;
	state_t              next_state;
	logic [23:0]         colour_q;
	logic                tri_done_q;

	logic                edge_start;
	logic                edge_advance;
	logic                span_start;
	logic                span_advance;
	raster_pkg::vertex_t a_pt;
	raster_pkg::vertex_t b_pt;
	raster_pkg::vertex_t span_pt;
	logic                a_last;
	logic                b_last;
	logic                span_last;
	logic                in_frame;

	line_stepper edge_a (.clk(clk), .reset(reset), .start(edge_start),
		.p0(triangle.v1), .p1(triangle.v3), .advance(edge_advance),
		.point(a_pt), .last(a_last));

	line_stepper edge_b (.clk(clk), .reset(reset), .start(edge_start),
		.p0(triangle.v2), .p1(triangle.v3), .advance(edge_advance),
		.point(b_pt), .last(b_last));

	line_stepper span (.clk(clk), .reset(reset), .start(span_start),
		.p0(a_pt), .p1(b_pt), .advance(span_advance),
		.point(span_pt), .last(span_last));

	// ********************
	// clipping and pixel address
	// ********************
	assign in_frame   = (span_pt.x < `RASTER_FB_WIDTH) && (span_pt.y < `RASTER_FB_HEIGHT);
	assign pix.adr    = `RASTER_ADDR_W'(span_pt.y * `RASTER_FB_WIDTH + span_pt.x);
	assign pix.rgb    = colour_q;
	assign pix_valid  = (state == EMIT) && in_frame;
	assign pixel_done = pix_valid && pix_ready;
	assign busy       = (state != IDLE);
	assign tri_done   = tri_done_q;

	always_comb
	begin
		next_state   = state;
		edge_start   = 1'b0;
		edge_advance = 1'b0;
		span_start   = 1'b0;
		span_advance = 1'b0;
		case (state)
			IDLE:
			begin
				edge_start = start;
				if (start)
					next_state = LOAD_EDGES;
			end
			LOAD_EDGES: next_state = LOAD_SPAN;       // edge points settle here
			LOAD_SPAN:
			begin
				span_start = 1'b1;
				next_state = EMIT;
			end
			EMIT:
			begin
				if (!in_frame || pix_ready)             // clipped points are skipped silently
					next_state = STEP_SPAN;
			end
			STEP_SPAN:
			begin
				span_advance = !span_last;
				next_state   = span_last ? STEP_EDGES : EMIT;
			end
			STEP_EDGES:
			begin
				edge_advance = 1'b1;                    // a finished edge holds its endpoint
				next_state   = (a_last && b_last) ? DONE : LOAD_SPAN;
			end
			DONE:
			begin
				if (pix_ready)                          // the last write has been acked
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state      <= IDLE;
			tri_done_q <= 1'b0;
		end
		else
		begin
			state      <= next_state;
			tri_done_q <= (state == DONE) && pix_ready;  // lands with busy falling
		end
	end

	always_ff @(posedge clk)
	begin
		if (edge_start)
			colour_q <= colour;
	end

endmodule

// File: raster_settings.svh
// ********************
// global sizes for the triangle rasteriser, framebuffer geometry and
// coordinate and address widths, included by every file that needs them
// ********************

`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// framebuffer geometry in pixels
`define RASTER_FB_WIDTH  640
`define RASTER_FB_HEIGHT 480

// unsigned vertex coordinate width
`define RASTER_COORD_W   16

// pixel address width, enough for 640 * 480 words
`define RASTER_ADDR_W    19

`endif

// File: tb.f
+incdir+.
design/raster_pkg.sv
design/line_stepper.sv
design/triangle_rasteriser.sv
design/raster_regs.sv
design/fb_write_master.sv
design/raster_top.sv
tb/raster_assertions.sv
tb/raster_tb.sv

// File: tb/raster_assertions.sv
// ********************
// Wishbone protocol checks, bound to the framebuffer master and to the
// host register slave, with a one-cycle check on tri_done
// ********************
`timescale 1ns/1ps

module raster_assertions (
	input logic        clk,
	input logic        reset,
	input logic        stb,
	input logic        ack,
	input logic [31:0] adr,
	input logic [31:0] dat,
	input logic        done
);

	// classic cycle: the master keeps stb up until the slave acks
	stb_held: assert property (@(posedge clk) disable iff (!reset)
		(stb && !ack) |=> stb)
		else $error("stb dropped before ack");

	addr_data_stable: assert property (@(posedge clk) disable iff (!reset)
		(stb && !ack) |=> ($stable(adr) && $stable(dat)))
		else $error("adr or dat changed while waiting for ack");

	ack_with_stb: assert property (@(posedge clk) disable iff (!reset)
		ack |-> stb)
		else $error("ack seen without stb");

	done_one_cycle: assert property (@(posedge clk) disable iff (!reset)
		done |=> !done)
		else $error("tri_done lasted more than one cycle");

endmodule

bind fb_write_master raster_assertions fb_checks (.clk(clk), .reset(reset),
	.stb(fb_m2s.stb), .ack(fb_s2m.ack), .adr(fb_m2s.adr), .dat(fb_m2s.dat),
	.done(1'b0));

bind raster_regs raster_assertions host_checks (.clk(clk), .reset(reset),
	.stb(host_m2s.stb), .ack(host_s2m.ack), .adr(host_m2s.adr), .dat(host_m2s.dat),
	.done(tri_done));

// File: tb/raster_tb.sv
// ********************
// testbench for the rasteriser, host register tasks, a framebuffer slave
// with random wait states and a Bresenham model of the expected writes
// ********************
`timescale 1ns/1ps
`include "raster_settings.svh"

module raster_tb;

	localparam int TRI_BUDGET      = 10_000;              // cycles allowed for one triangle
	localparam int WATCHDOG_CYCLES = 20 * TRI_BUDGET;     // 14 triangles plus register tests
	localparam int FBW             = `RASTER_FB_WIDTH;
	localparam int FBH             = `RASTER_FB_HEIGHT;

	logic                clk;
	logic                reset;
	raster_pkg::wb_m2s_t host_m2s;
	raster_pkg::wb_s2m_t host_s2m;
	raster_pkg::wb_m2s_t fb_m2s;
	raster_pkg::wb_s2m_t fb_s2m;
	logic                tri_done;

	int fb_adr_q[$];                                      // writes seen by the framebuffer
	int fb_dat_q[$];
	int exp_adr[$];                                       // writes predicted by the model
	int exp_dat[$];
	int done_pulses;
	int vtx[6];                                           // x1 y1 x2 y2 x3 y3 of the next triangle
	// model of the three steppers, index 0 is edge a, 1 is edge b, 2 is the span
	int lx[3];
	int ly[3];
	int ex[3];
	int ey[3];
	int ldx[3];
	int ldy[3];
	int lerr[3];
	int lsx[3];
	int lsy[3];

	raster_top u_raster_top (.clk(clk), .reset(reset), .host_m2s(host_m2s),
		.host_s2m(host_s2m), .fb_m2s(fb_m2s), .fb_s2m(fb_s2m), .tri_done(tri_done));

	always #5 clk = ~clk;

	always @(negedge clk)
	begin
		if (tri_done)
			done_pulses++;                                  // counted mid-cycle where it is stable
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected)
		else report_error($sformatf("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
			$time, name, got, expected));
	endtask

	// ********************
	// framebuffer slave
	// ********************
	initial
	begin : fb_model
		int waits;
		fb_s2m = '0;
		forever
		begin
			@(posedge clk);
			#1;
			if (fb_m2s.cyc && fb_m2s.stb)
			begin
				waits = $urandom_range(3, 0);
				repeat (waits)
				begin
					@(posedge clk);
					#1;
				end
				fb_s2m.ack = 1'b1;
				check_value("fb_m2s.we", fb_m2s.we, 1);
				check_value("fb_m2s.sel", fb_m2s.sel, 4'hf);
				assert (fb_m2s.adr < FBW * FBH)
				else report_error("a write address lies beyond the framebuffer");
				fb_adr_q.push_back(fb_m2s.adr);
				fb_dat_q.push_back(fb_m2s.dat);
				@(posedge clk);                             // master sees ack at this edge
				#1;
				fb_s2m.ack = 1'b0;
			end
		end
	end

	task automatic bus_cycle(input int adr, input logic we, input int wdat, output int rdat);
		int n;
		@(posedge clk);
		#1;
		host_m2s.cyc = 1'b1;
		host_m2s.stb = 1'b1;
		host_m2s.we  = we;
		host_m2s.sel = 4'hf;
		host_m2s.adr = adr;
		host_m2s.dat = wdat;
		n = 0;
		while (!host_s2m.ack && n < 16)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (host_s2m.ack) else report_error("host bus access got no ack");
		rdat = host_s2m.dat;
		@(posedge clk);                                   // hold stb through the ack edge
		#1;
		host_m2s = '0;
	endtask

	task automatic write_reg(input int adr, input int dat);
		int unused;
		bus_cycle(adr, 1'b1, dat, unused);
	endtask

	task automatic read_reg(input int adr, output int dat);
		bus_cycle(adr, 1'b0, 0, dat);
	endtask

	// ********************
	// reference model
	// ********************
	function automatic void line_begin(input int i, input int x0, input int y0,
		input int x1, input int y1);
		lx[i]   = x0;
		ly[i]   = y0;
		ex[i]   = x1;
		ey[i]   = y1;
		ldx[i]  = (x1 >= x0) ? x1 - x0 : x0 - x1;
		ldy[i]  = (y1 >= y0) ? y0 - y1 : y1 - y0;         // zero or negative
		lsx[i]  = (x1 >= x0) ? 1 : -1;
		lsy[i]  = (y1 >= y0) ? 1 : -1;
		lerr[i] = ldx[i] + ldy[i];
	endfunction

	function automatic logic line_end(input int i);
		return (lx[i] == ex[i]) && (ly[i] == ey[i]);
	endfunction

	function automatic void line_step(input int i);
		int e2;
		e2 = 2 * lerr[i];
		if (!line_end(i))                                 // a line at its endpoint holds there
		begin
			if (e2 >= ldy[i])
			begin
				lerr[i] += ldy[i];
				lx[i]   += lsx[i];
			end
			if (e2 <= ldx[i])
			begin
				lerr[i] += ldx[i];
				ly[i]   += lsy[i];
			end
		end
	endfunction

	task automatic predict_writes(input int rgb);
		logic edges_done;
		logic span_done;
		exp_adr.delete();
		exp_dat.delete();
		line_begin(0, vtx[0], vtx[1], vtx[4], vtx[5]);
		line_begin(1, vtx[2], vtx[3], vtx[4], vtx[5]);
		edges_done = 1'b0;
		while (!edges_done)
		begin
			line_begin(2, lx[0], ly[0], lx[1], ly[1]);
			span_done = 1'b0;
			while (!span_done)
			begin
				if (lx[2] < FBW && ly[2] < FBH)               // off-screen points give no write
				begin
					exp_adr.push_back(ly[2] * FBW + lx[2]);
					exp_dat.push_back(rgb);
				end
				span_done = line_end(2);
				line_step(2);
			end
			edges_done = line_end(0) && line_end(1);
			line_step(0);
			line_step(1);
		end
	endtask

	task automatic draw_triangle(input int rgb, input logic second_start);
		int status;
		int n;
		int first;
		int pulses;
		for (int i = 0; i < 6; i++)
			write_reg(i, vtx[i]);
		write_reg(6, rgb);
		predict_writes(rgb);
		first  = fb_adr_q.size();
		pulses = done_pulses;
		write_reg(7, 1);
		if (second_start)
		begin
			while (fb_adr_q.size() == first)                // some pixels are counted before it
				@(posedge clk);
			read_reg(7, status);
			check_value("status busy", status[0], 1);
			write_reg(7, 1);                                // arrives while busy
		end
		n = 0;
		while (!tri_done && n < TRI_BUDGET)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (tri_done) else report_error("tri_done did not arrive within the cycle budget");
		check_value("write count", fb_adr_q.size() - first, exp_adr.size());
		for (int i = 0; i < exp_adr.size(); i++)
		begin
			check_value("fb_m2s.adr", fb_adr_q[first + i], exp_adr[i]);
			check_value("fb_m2s.dat", fb_dat_q[first + i], exp_dat[i]);
		end
		read_reg(7, status);
		check_value("status busy", status[0], 0);
		check_value("status count", status[31:16], exp_adr.size());
		check_value("tri_done pulses", done_pulses - pulses, 1);
	endtask

	// ********************
	// directed tests
	// ********************
	task automatic check_readback();
		int rd;
		vtx = '{11, 22, 333, 444, 555, 66};
		for (int i = 0; i < 6; i++)
			write_reg(i, vtx[i]);
		write_reg(6, 24'h12abef);
		for (int i = 0; i < 6; i++)
		begin
			read_reg(i, rd);
			check_value($sformatf("host_s2m.dat reg %0d", i), rd, vtx[i]);
		end
		read_reg(6, rd);
		check_value("host_s2m.dat colour", rd, 24'h12abef);
		read_reg(7, rd);
		check_value("status busy", rd[0], 0);
	endtask

	task automatic degenerate_triangle();
		int first;
		vtx   = '{100, 200, 100, 200, 100, 200};
		first = fb_adr_q.size();
		draw_triangle(24'h00ff00, 1'b0);
		check_value("write count", fb_adr_q.size() - first, 1);
		check_value("fb_m2s.adr", fb_adr_q[first], 200 * 640 + 100);
	endtask

	task automatic random_triangles();
		for (int t = 0; t < 10; t++)
		begin
			for (int i = 0; i < 6; i++)
				vtx[i] = $urandom_range(63, 0);
			draw_triangle($urandom & 24'hffffff, 1'b0);
		end
	endtask

	initial
	begin
		void'($urandom(16));
		clk         = 1'b0;
		reset       = 1'b0;
		host_m2s    = '0;
		done_pulses = 0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b1;
		check_readback();
		degenerate_triangle();
		vtx = '{10, 5, 52, 18, 23, 47};                   // general triangle
		draw_triangle(24'h3366cc, 1'b0);
		vtx = '{620, 460, 660, 470, 630, 500};            // crosses the right and bottom border
		draw_triangle(24'hff8000, 1'b0);
		vtx = '{3, 60, 58, 40, 30, 2};                    // second start must be ignored
		draw_triangle(24'h0000ff, 1'b1);
		random_triangles();
		$display("TEST PASSED");
		$finish;
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_error("watchdog expired before all tests finished");
	end

endmodule
